// ==== include/cdc_channel_cfg.svh ====
////////////////////////////////////////////////////////////////////////////
// configuration macros of the cdc channel
// data width, fifo address width, almost-full threshold
////////////////////////////////////////////////////////////////////////////

`ifndef CDC_CHANNEL_CFG_SVH
`define CDC_CHANNEL_CFG_SVH

// bits per fifo word
`define CDC_DATA_W 32

// depth is 2**CDC_ADDR_W entries
`define CDC_ADDR_W 4

// almost_full once free entries drop to this or fewer
`define CDC_AF_THRESHOLD 4

`endif

// ==== rtl/cdc_channel_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types of the cdc channel
// data word, ram pointer, occupancy count, drop count
////////////////////////////////////////////////////////////////////////////

`include "cdc_channel_cfg.svh"

package cdc_channel_pkg;

	// one fifo word
	typedef logic [`CDC_DATA_W-1:0] data_t;

	// ram address
	typedef logic [`CDC_ADDR_W-1:0] ptr_t;

	// occupancy, one extra bit so that a full fifo fits
	typedef logic [`CDC_ADDR_W:0] count_t;

	// refused writes, saturating
	typedef logic [15:0] drop_count_t;

endpackage

// ==== rtl/fifo_wr_if.sv ====
////////////////////////////////////////////////////////////////////////////
// write side bundle between write port and fifo
// strobe, data, full and almost_full flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface fifo_wr_if;

	// write strobe, one word per clk_a edge
	logic wr;
	// word to store
	cdc_channel_pkg::data_t wr_data;
	// fifo status, clk_a domain
	logic full;
	logic almost_full;

	// writer side
	modport wr_port (
		output wr,
		output wr_data,
		input full,
		input almost_full
	);

	// fifo side
	modport fifo_side (
		input wr,
		input wr_data,
		output full,
		output almost_full
	);

endinterface

// ==== rtl/cdc_event_sync.sv ====
////////////////////////////////////////////////////////////////////////////
// event crossing between two clock domains
// source count kept in gray code, two-flop sync into the destination,
// replayed there as one pulse per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cdc_event_sync (
	input logic src_clk,
	input logic dst_clk,
	input logic rst_n,
	input logic event_in,
	output logic event_out
);

	// gray to binary, each bit is the xor of all higher gray bits
	function automatic cdc_channel_pkg::count_t gray2bin(input cdc_channel_pkg::count_t g);
		cdc_channel_pkg::count_t b;
		b = g;
		for (int i = 1; i < $bits(g); i++) begin
			b = b ^ (g >> i);
		end
		return b;
	endfunction

	// source domain
	cdc_channel_pkg::count_t src_bin;
	cdc_channel_pkg::count_t src_bin_nxt;
	cdc_channel_pkg::count_t src_gray;

	// destination domain
	cdc_channel_pkg::count_t sync_q1;
	cdc_channel_pkg::count_t sync_q2;
	cdc_channel_pkg::count_t dst_bin;
	cdc_channel_pkg::count_t rep_cnt;

	assign src_bin_nxt = src_bin + 1'b1;

	// count source events, gray copy updates on the same edge
	// only one gray bit flips per event, safe to sample anywhere
	always_ff @(posedge src_clk or negedge rst_n) begin
		if (!rst_n) begin
			src_bin <= '0;
			src_gray <= '0;
		end else if (event_in) begin
			src_bin <= src_bin_nxt;
			src_gray <= src_bin_nxt ^ (src_bin_nxt >> 1);
		end
	end

	// two-flop synchronizer
	always_ff @(posedge dst_clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= src_gray;
			sync_q2 <= sync_q1;
		end
	end

	assign dst_bin = gray2bin(sync_q2);

	// replay until local count catches up
	// wraps together with the source count
	assign event_out = (dst_bin != rep_cnt);

	always_ff @(posedge dst_clk or negedge rst_n) begin
		if (!rst_n) begin
			rep_cnt <= '0;
		end else if (event_out) begin
			rep_cnt <= rep_cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/fifo_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// distributed ram of the fifo
// clk_a write port, unregistered read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fifo_ram (
	input logic clk_a,
	input logic wr,
	input cdc_channel_pkg::ptr_t wr_addr,
	input cdc_channel_pkg::ptr_t rd_addr,
	input cdc_channel_pkg::data_t wr_data,
	output cdc_channel_pkg::data_t rd_data
);

	// one entry per pointer value
	localparam int DEPTH = 2 ** $bits(cdc_channel_pkg::ptr_t);

	cdc_channel_pkg::data_t mem [DEPTH];

	// store on the write strobe
	always_ff @(posedge clk_a) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// async read, head word shows as soon as the pointer moves
	assign rd_data = mem[rd_addr];

endmodule

// ==== rtl/async_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// asynchronous fifo, clk_a write side and clk_b read side
// pointers, occupancy of both domains, status flags,
// event crossing in both directions and the storage ram
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cdc_channel_cfg.svh"

module async_fifo (
	input logic clk_a,
	input logic clk_b,
	input logic rst_n,
	fifo_wr_if.fifo_side wr_if,
	input logic read,
	output cdc_channel_pkg::data_t read_data,
	output logic empty
);

	// depth and almost-full level as occupancy values
	localparam cdc_channel_pkg::count_t DEPTH = 1 << `CDC_ADDR_W;
	localparam cdc_channel_pkg::count_t AF_LEVEL = DEPTH - `CDC_AF_THRESHOLD;

	// clk_a side
	cdc_channel_pkg::ptr_t wr_ptr;
	cdc_channel_pkg::count_t occ_a;
	logic pop_a;

	// clk_b side
	cdc_channel_pkg::ptr_t rd_ptr;
	cdc_channel_pkg::count_t occ_b;
	logic push_b;
	logic pop;

	// writes replayed in clk_b
	cdc_event_sync u_wr_sync (
		.src_clk (clk_a),
		.dst_clk (clk_b),
		.rst_n (rst_n),
		.event_in (wr_if.wr),
		.event_out (push_b)
	);

	// pops replayed in clk_a
	cdc_event_sync u_rd_sync (
		.src_clk (clk_b),
		.dst_clk (clk_a),
		.rst_n (rst_n),
		.event_in (pop),
		.event_out (pop_a)
	);

	// write pointer
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (wr_if.wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// write-side occupancy
	// pops arrive late, so this count errs high
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			occ_a <= '0;
		end else if (wr_if.wr && !pop_a) begin
			occ_a <= occ_a + 1'b1;
		end else if (!wr_if.wr && pop_a) begin
			occ_a <= occ_a - 1'b1;
		end
	end

	// writer flags straight off the count
	assign wr_if.full = (occ_a == DEPTH);
	assign wr_if.almost_full = (occ_a >= AF_LEVEL);

	// reads while empty are dropped here
	assign pop = read && !empty;

	// read pointer
	always_ff @(posedge clk_b or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// read-side occupancy
	// writes arrive late, so this count errs low
	always_ff @(posedge clk_b or negedge rst_n) begin
		if (!rst_n) begin
			occ_b <= '0;
		end else if (push_b && !pop) begin
			occ_b <= occ_b + 1'b1;
		end else if (!push_b && pop) begin
			occ_b <= occ_b - 1'b1;
		end
	end

	assign empty = (occ_b == '0);

	// storage
	fifo_ram u_ram (
		.clk_a (clk_a),
		.wr (wr_if.wr),
		.wr_addr (wr_ptr),
		.rd_addr (rd_ptr),
		.wr_data (wr_if.wr_data),
		.rd_data (read_data)
	);

endmodule

// ==== rtl/fifo_write_port.sv ====
////////////////////////////////////////////////////////////////////////////
// write port stage in the clk_a domain
// blocks writes while full, counts the refused ones
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fifo_write_port (
	input logic clk_a,
	input logic rst_n,
	input logic write,
	input cdc_channel_pkg::data_t write_data,
	output cdc_channel_pkg::drop_count_t drop_count,
	fifo_wr_if.wr_port wr_if
);

	// request that hits a full fifo
	logic refused;

	assign refused = write && wr_if.full;

	// pass through only while there is room
	assign wr_if.wr = write && !wr_if.full;
	assign wr_if.wr_data = write_data;

	// drop counter, sticks at all ones
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			drop_count <= '0;
		end else if (refused && (drop_count != '1)) begin
			drop_count <= drop_count + 1'b1;
		end
	end

endmodule

// ==== rtl/cdc_channel.sv ====
////////////////////////////////////////////////////////////////////////////
// cdc data channel top level
// write port stage and asynchronous fifo, plain ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cdc_channel (
	input logic clk_a,
	input logic clk_b,
	input logic rst_n,
	// writer, clk_a domain
	input logic write,
	input cdc_channel_pkg::data_t write_data,
	output logic full,
	output logic almost_full,
	output cdc_channel_pkg::drop_count_t drop_count,
	// reader, clk_b domain
	input logic read,
	output cdc_channel_pkg::data_t read_data,
	output logic empty
);

	// write bundle between the two stages
	fifo_wr_if u_wr_if ();

	// refuses writes while full
	fifo_write_port u_write_port (
		.clk_a (clk_a),
		.rst_n (rst_n),
		.write (write),
		.write_data (write_data),
		.drop_count (drop_count),
		.wr_if (u_wr_if.wr_port)
	);

	// storage and crossing
	async_fifo u_fifo (
		.clk_a (clk_a),
		.clk_b (clk_b),
		.rst_n (rst_n),
		.wr_if (u_wr_if.fifo_side),
		.read (read),
		.read_data (read_data),
		.empty (empty)
	);

	// writer flags out to the top
	assign full = u_wr_if.full;
	assign almost_full = u_wr_if.almost_full;

endmodule

// ==== tests/tb_cdc_channel.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench of the cdc channel
// two clocks, stimulus table applied in a loop, reference queue,
// value check task and timed flag waits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cdc_channel_cfg.svh"

module tb_cdc_channel;

	localparam int DEPTH = 1 << `CDC_ADDR_W;
	localparam int AF_LEVEL = DEPTH - `CDC_AF_THRESHOLD;
	localparam int WAIT_LIMIT = 200;
	localparam int NUM_STEPS = 10;

	// one table row
	// burst rows run with reads idle, so the queue size is the true occupancy
	typedef struct packed {
		int n_wr;
		logic burst;
		int idle_rd;
		int n_rd;
		int gap_lo;
		int gap_hi;
		int exp_drop;
	} step_t;

	// writes, burst, blind reads, reads, read gap range, drop_count after the step
	step_t steps [NUM_STEPS] = '{
		'{40, 1'b0, 0, 40, 0, 3, 0},
		'{30, 1'b0, 0, 30, 0, 0, 0},
		'{11, 1'b1, 0, 0, 0, 0, 0},
		'{1, 1'b1, 0, 0, 0, 0, 0},
		'{3, 1'b1, 0, 0, 0, 0, 0},
		'{0, 1'b0, 0, 15, 0, 2, 0},
		'{DEPTH + 3, 1'b1, 0, 0, 0, 0, 3},
		'{0, 1'b0, 0, DEPTH, 0, 1, 3},
		'{5, 1'b0, 3, 5, 0, 2, 3},
		'{25, 1'b0, 0, 25, 1, 5, 3}
	};

	logic clk_a;
	logic clk_b;
	logic rst_n;
	logic write;
	cdc_channel_pkg::data_t write_data;
	logic full;
	logic almost_full;
	cdc_channel_pkg::drop_count_t drop_count;
	logic read;
	cdc_channel_pkg::data_t read_data;
	logic empty;

	// words the fifo should hold, oldest first
	cdc_channel_pkg::data_t model [$];

	cdc_channel i_cdc_channel (
		.clk_a (clk_a),
		.clk_b (clk_b),
		.rst_n (rst_n),
		.write (write),
		.write_data (write_data),
		.full (full),
		.almost_full (almost_full),
		.drop_count (drop_count),
		.read (read),
		.read_data (read_data),
		.empty (empty)
	);

	// writer clock, 20 ns
	initial begin
		clk_a = 1'b0;
		forever #10 clk_a = ~clk_a;
	end

	// reader clock, 34 ns
	initial begin
		clk_b = 1'b0;
		forever #17 clk_b = ~clk_b;
	end

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("TIMEOUT at %0t: %s", $time, what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// sampled on falling edges, away from the flops
	task automatic wait_room();
		int cycles;
		@(negedge clk_a);
		for (cycles = 0; full && (cycles < WAIT_LIMIT); cycles++) begin
			@(negedge clk_a);
		end
		if (full) fail_timeout("full never fell within 200 clk_a cycles");
	endtask

	task automatic wait_data();
		int cycles;
		@(negedge clk_b);
		for (cycles = 0; empty && (cycles < WAIT_LIMIT); cycles++) begin
			@(negedge clk_b);
		end
		if (empty) fail_timeout("empty never fell within 200 clk_b cycles");
	endtask

	// burst: one write per edge, words past a full fifo are dropped
	// otherwise one write per two edges, only after room is seen
	task automatic do_writes(input int n, input logic burst);
		cdc_channel_pkg::data_t d;
		for (int i = 0; i < n; i++) begin
			d = $urandom();
			if (burst) begin
				@(posedge clk_a);
				write <= 1'b1;
				write_data <= d;
				if (model.size() < DEPTH) model.push_back(d);
			end else begin
				wait_room();
				@(posedge clk_a);
				write <= 1'b1;
				write_data <= d;
				model.push_back(d);
				@(posedge clk_a);
				write <= 1'b0;
			end
		end
		@(posedge clk_a);
		write <= 1'b0;
	endtask

	// random idle gap, then pop the head and compare
	task automatic do_reads(input int n, input int gap_lo, input int gap_hi);
		int gap;
		for (int i = 0; i < n; i++) begin
			gap = gap_lo + ($urandom() % (gap_hi - gap_lo + 1));
			repeat (gap) @(posedge clk_b);
			wait_data();
			check_value(model.size() != 0, 1'b1, "word visible with nothing written");
			check_value(read_data, model[0], $sformatf("read data of word %0d", i));
			void'(model.pop_front());
			@(posedge clk_b);
			read <= 1'b1;
			@(posedge clk_b);
			read <= 1'b0;
		end
	endtask

	// reads into an empty fifo, must be ignored
	task automatic blind_reads(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_b);
			check_value(empty, 1'b1, "empty before blind read");
			@(posedge clk_b);
			read <= 1'b1;
			@(posedge clk_b);
			read <= 1'b0;
		end
	endtask

	// flags are exact after 8 idle cycles of the slower clock
	task automatic settle_and_check(input int exp_drop, input int idx);
		repeat (8) @(posedge clk_b);
		@(negedge clk_a);
		check_value(full, model.size() == DEPTH, $sformatf("step %0d full", idx));
		check_value(almost_full, model.size() >= AF_LEVEL,
			$sformatf("step %0d almost_full", idx));
		check_value(drop_count, exp_drop, $sformatf("step %0d drop_count", idx));
		@(negedge clk_b);
		check_value(empty, model.size() == 0, $sformatf("step %0d empty", idx));
	endtask

	task automatic run_step(input step_t st, input int idx);
		blind_reads(st.idle_rd);
		fork
			do_writes(st.n_wr, st.burst);
			do_reads(st.n_rd, st.gap_lo, st.gap_hi);
		join
		settle_and_check(st.exp_drop, idx);
	endtask

	initial begin
		void'($urandom(54));
		rst_n = 1'b0;
		write = 1'b0;
		write_data = '0;
		read = 1'b0;
		repeat (10) @(posedge clk_a);
		rst_n <= 1'b1;

		// reset values
		@(negedge clk_a);
		check_value(full, 1'b0, "full after reset");
		check_value(almost_full, 1'b0, "almost_full after reset");
		check_value(drop_count, 0, "drop_count after reset");
		@(negedge clk_b);
		check_value(empty, 1'b1, "empty after reset");

		for (int s = 0; s < NUM_STEPS; s++) begin
			run_step(steps[s], s);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== cdc_channel.f ====
+incdir+include
rtl/cdc_channel_pkg.sv
rtl/fifo_wr_if.sv
rtl/cdc_event_sync.sv
rtl/fifo_ram.sv
rtl/async_fifo.sv
rtl/fifo_write_port.sv
rtl/cdc_channel.sv
tests/tb_cdc_channel.sv

// ==== Bender.yml ====
package:
  name: cdc_channel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/cdc_channel_pkg.sv
      - rtl/fifo_wr_if.sv
      - rtl/cdc_event_sync.sv
      - rtl/fifo_ram.sv
      - rtl/async_fifo.sv
      - rtl/fifo_write_port.sv
      - rtl/cdc_channel.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_cdc_channel.sv
